// File: src.f
logic/soc_bus_pkg.sv
logic/soc_periph_pkg.sv
logic/soc_bus_if.sv
logic/bus_arbiter.sv
logic/main_bus_decode.sv
logic/block_ram.sv
logic/peripheral_bridge.sv
logic/system_timer.sv
logic/soc_fabric.sv
dv/tb_soc_fabric.sv

// File: dv/soc_bus_patterns.txt
# columns: test port op address wdata expected (hex), port i d m or - when unused
# ops: wr write, rd read and compare, ge read lower bound, led o_ledr, irq wait for level
led_at_reset   -  led  00000000 00000000 00000000
ram_wr_a       d  wr   10000000 11112222 00000000
ram_wr_b       d  wr   10000004 33334444 00000000
ram_wr_c       d  wr   100007fc a5a5a5a5 00000000
ram_rd_a       d  rd   10000000 00000000 11112222
ram_rd_c       d  rd   100007fc 00000000 a5a5a5a5
ram_rd_b       d  rd   10000004 00000000 33334444
dma_wr_a       m  wr   10000000 deadbeef 00000000
ifetch_a       i  rd   10000000 00000000 deadbeef
ifetch_b       i  rd   10000004 00000000 33334444
# all three ports at once, the reads touch words the group does not write
parallel
par_ifetch     i  rd   100007fc 00000000 a5a5a5a5
par_dbus_rd    d  rd   10000004 00000000 33334444
par_dma_wr     m  wr   10000100 0badf00d 00000000
parallel
par_ifetch_2   i  rd   10000000 00000000 deadbeef
par_dbus_wr    d  wr   10000108 cafe0001 00000000
par_dma_wr_2   m  wr   10000104 12345678 00000000
dma_seen_a     d  rd   10000100 00000000 0badf00d
dma_seen_b     d  rd   10000104 00000000 12345678
dbus_seen      i  rd   10000108 00000000 cafe0001
led_write      d  wr   50000000 fffff2a5 00000000
led_value      -  led  00000000 00000000 000002a5
led_read       d  rd   50000000 00000000 00000000
unmapped_rd    d  rd   30000000 00000000 00000000
far_unmapped   d  rd   52000000 00000000 00000000
dma_unmapped   m  rd   7ffffffc 00000000 00000000
tmr_compare    d  wr   55000004 00000040 00000000
tmr_cmp_rd     d  rd   55000004 00000000 00000040
tmr_enable     d  wr   55000008 00000001 00000000
tmr_irq_on     -  irq  00000000 00000000 00000001
tmr_control    d  rd   55000008 00000000 00000003
tmr_count      d  ge   55000000 00000000 00000040
tmr_clear      d  wr   55000008 00000002 00000000
tmr_irq_off    -  irq  00000000 00000000 00000000
tmr_ctrl_idle  d  rd   55000008 00000000 00000000

// File: dv/tb_soc_fabric.sv
`default_nettype none
`timescale 1ns/1ns

module tb_soc_fabric;
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;

	localparam int TIMEOUT_CYCLES = 100;

	logic clock;
	logic rst;
	logic ibus_request;
	addr_t ibus_address;
	data_t ibus_rdata;
	logic ibus_ready;
	logic dbus_request;
	logic dbus_rw;
	addr_t dbus_address;
	data_t dbus_wdata;
	data_t dbus_rdata;
	logic dbus_ready;
	logic dma_request;
	logic dma_rw;
	addr_t dma_address;
	data_t dma_wdata;
	data_t dma_rdata;
	logic dma_ready;
	logic [LED_W-1:0] ledr;
	logic timer_irq;

	int check_count = 0;
	int mismatch_count = 0;
	int fail_count = 0;

	soc_fabric i_dut (
		.i_clock        (clock),
		.i_rst          (rst),
		.i_ibus_request (ibus_request),
		.i_ibus_address (ibus_address),
		.o_ibus_rdata   (ibus_rdata),
		.o_ibus_ready   (ibus_ready),
		.i_dbus_request (dbus_request),
		.i_dbus_rw      (dbus_rw),
		.i_dbus_address (dbus_address),
		.i_dbus_wdata   (dbus_wdata),
		.o_dbus_rdata   (dbus_rdata),
		.o_dbus_ready   (dbus_ready),
		.i_dma_request  (dma_request),
		.i_dma_rw       (dma_rw),
		.i_dma_address  (dma_address),
		.i_dma_wdata    (dma_wdata),
		.o_dma_rdata    (dma_rdata),
		.o_dma_ready    (dma_ready),
		.o_ledr         (ledr),
		.o_timer_irq    (timer_irq)
	);

	always #10 clock = ~clock;

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		end
	endtask

	function automatic string port_label(input logic [63:0] port);
		case (port)
			"i":     return "instruction";
			"d":     return "data";
			"m":     return "DMA";
			default: return "unknown";
		endcase
	endfunction

	function automatic logic port_ready(input logic [63:0] port);
		case (port)
			"i":     return ibus_ready;
			"d":     return dbus_ready;
			default: return dma_ready;
		endcase
	endfunction

	function automatic data_t port_rdata(input logic [63:0] port);
		case (port)
			"i":     return ibus_rdata;
			"d":     return dbus_rdata;
			default: return dma_rdata;
		endcase
	endfunction

	// ========================================================================
	// One transaction on one master port
	// ========================================================================
	task automatic bus_transfer(input string name, input logic [63:0] port, input logic rw,
			input addr_t addr, input data_t wdata, output data_t rdata);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		rdata = '0;
		@(posedge clock);
		case (port)
			"i": begin
				ibus_request <= 1'b1;
				ibus_address <= addr;
			end
			"d": begin
				dbus_request <= 1'b1;
				dbus_rw      <= rw;
				dbus_address <= addr;
				dbus_wdata   <= wdata;
			end
			default: begin
				dma_request <= 1'b1;
				dma_rw      <= rw;
				dma_address <= addr;
				dma_wdata   <= wdata;
			end
		endcase
		// Ready is a one-cycle pulse, look at it mid-cycle
		while (!seen && cycles < TIMEOUT_CYCLES) begin
			@(negedge clock);
			cycles++;
			if (port_ready(port) === 1'b1) begin
				seen = 1'b1;
				rdata = port_rdata(port);
			end
		end
		if (!seen) begin
			fail_count++;
			$display("Timeout: no ready on the %s port in test %s", port_label(port), name);
		end
		@(posedge clock);
		case (port)
			"i":     ibus_request <= 1'b0;
			"d":     dbus_request <= 1'b0;
			default: dma_request <= 1'b0;
		endcase
	endtask

	task automatic wait_irq(input string name, input logic level);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < TIMEOUT_CYCLES) begin
			@(negedge clock);
			cycles++;
			if (timer_irq === level)
				seen = 1'b1;
		end
		if (!seen) begin
			fail_count++;
			$display("Timeout: timer interrupt never went to %0d in test %s", level, name);
		end
	endtask

	task automatic run_entry(input string name, input logic [63:0] port,
			input logic [63:0] op, input addr_t addr, input data_t wdata,
			input data_t expected);
		data_t rdata;
		if (op == "led") begin
			@(negedge clock);
			check_value(name, expected, 32'(ledr));
		end else if (op == "irq") begin
			wait_irq(name, expected[0]);
		end else if (port_label(port) == "unknown") begin
			fail_count++;
			$display("Pattern error: test %s names an unknown port", name);
		end else begin
			bus_transfer(name, port, op == "wr", addr, wdata, rdata);
			if (op == "rd") begin
				check_value(name, expected, rdata);
			end else if (op == "ge") begin
				check_count++;
				if (rdata < expected) begin
					fail_count++;
					$display("Test %s read %h, which is below the lower bound %h",
						name, rdata, expected);
				end
			end
		end
	endtask

	// ========================================================================
	// Pattern file reader
	// ========================================================================
	task automatic next_token(input integer fd, output logic [8*24-1:0] tok, output logic ok);
		integer code;
		integer c;
		logic done;
		ok = 1'b0;
		done = 1'b0;
		tok = '0;
		while (!done) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1) begin
				done = 1'b1;
			end else if (tok == "#") begin
				c = $fgetc(fd);
				while (c != 10 && c != -1)
					c = $fgetc(fd);
			end else begin
				ok = 1'b1;
				done = 1'b1;
			end
		end
	endtask

	task automatic read_fields(input integer fd, output logic [63:0] port,
			output logic [63:0] op, output addr_t addr, output data_t wdata,
			output data_t expected, output logic ok);
		integer code;
		code = $fscanf(fd, "%s %s %h %h %h", port, op, addr, wdata, expected);
		ok = (code == 5);
	endtask

	initial begin
		integer fd;
		logic reading;
		logic ok;
		logic fields_ok;
		logic [8*24-1:0] tok;
		logic [63:0] port;
		logic [63:0] op;
		addr_t addr;
		data_t wdata;
		data_t expected;
		string par_name [3];
		logic [63:0] par_port [3];
		logic [63:0] par_op [3];
		addr_t par_addr [3];
		data_t par_wdata [3];
		data_t par_expected [3];

		clock = 1'b0;
		rst <= 1'b1;
		ibus_request <= 1'b0;
		ibus_address <= '0;
		dbus_request <= 1'b0;
		dbus_rw <= 1'b0;
		dbus_address <= '0;
		dbus_wdata <= '0;
		dma_request <= 1'b0;
		dma_rw <= 1'b0;
		dma_address <= '0;
		dma_wdata <= '0;

		repeat (4) @(posedge clock);
		rst <= 1'b0;

		@(negedge clock);
		check_value("reset_ibus_ready", 32'd0, 32'(ibus_ready));
		check_value("reset_dbus_ready", 32'd0, 32'(dbus_ready));
		check_value("reset_dma_ready", 32'd0, 32'(dma_ready));
		check_value("reset_timer_irq", 32'd0, 32'(timer_irq));
		check_value("reset_ledr", 32'd0, 32'(ledr));

		fd = $fopen("dv/soc_bus_patterns.txt", "r");
		reading = (fd != 0);
		if (fd == 0) begin
			fail_count++;
			$display("Could not open the pattern file dv/soc_bus_patterns.txt");
		end

		while (reading) begin
			next_token(fd, tok, ok);
			if (!ok) begin
				reading = 1'b0;
			end else if (tok == "parallel") begin
				// One line per port, all three requests go out together
				fields_ok = 1'b1;
				for (int k = 0; k < 3; k++) begin
					next_token(fd, tok, ok);
					par_name[k] = string'(tok);
					read_fields(fd, par_port[k], par_op[k], par_addr[k], par_wdata[k],
						par_expected[k], reading);
					fields_ok = fields_ok && ok && reading;
				end
				if (fields_ok) begin
					fork
						run_entry(par_name[0], par_port[0], par_op[0], par_addr[0],
							par_wdata[0], par_expected[0]);
						run_entry(par_name[1], par_port[1], par_op[1], par_addr[1],
							par_wdata[1], par_expected[1]);
						run_entry(par_name[2], par_port[2], par_op[2], par_addr[2],
							par_wdata[2], par_expected[2]);
					join
				end else begin
					fail_count++;
					reading = 1'b0;
					$display("Pattern file ends inside a parallel group");
				end
			end else begin
				read_fields(fd, port, op, addr, wdata, expected, ok);
				if (ok) begin
					run_entry(string'(tok), port, op, addr, wdata, expected);
				end else begin
					fail_count++;
					reading = 1'b0;
					$display("Malformed pattern line for test %s", string'(tok));
				end
			end
		end
		if (fd != 0)
			$fclose(fd);

		$display("Checks %0d, mismatches %0d, other errors %0d",
			check_count, mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/soc_fabric.sv
`default_nettype none
`timescale 1ns/1ns

module soc_fabric (
	input  wire                                 i_clock,
	input  wire                                 i_rst,

	input  wire                                 i_ibus_request,
	input  wire soc_bus_pkg::addr_t             i_ibus_address,
	output wire soc_bus_pkg::data_t             o_ibus_rdata,
	output wire                                 o_ibus_ready,

	input  wire                                 i_dbus_request,
	input  wire                                 i_dbus_rw,
	input  wire soc_bus_pkg::addr_t             i_dbus_address,
	input  wire soc_bus_pkg::data_t             i_dbus_wdata,
	output wire soc_bus_pkg::data_t             o_dbus_rdata,
	output wire                                 o_dbus_ready,

	input  wire                                 i_dma_request,
	input  wire                                 i_dma_rw,
	input  wire soc_bus_pkg::addr_t             i_dma_address,
	input  wire soc_bus_pkg::data_t             i_dma_wdata,
	output wire soc_bus_pkg::data_t             o_dma_rdata,
	output wire                                 o_dma_ready,

	output wire [soc_periph_pkg::LED_W-1:0]     o_ledr,
	output wire                                 o_timer_irq
);

	soc_bus_if sys_bus ();
	soc_bus_if ram_bus ();
	soc_bus_if near_bus ();
	soc_bus_if timer_bus ();

	// ========================================================================
	// Masters onto the system bus
	// ========================================================================
	bus_arbiter arbiter (
		.i_clock        (i_clock),
		.i_rst          (i_rst),
		.i_ibus_request (i_ibus_request),
		.i_ibus_address (i_ibus_address),
		.o_ibus_rdata   (o_ibus_rdata),
		.o_ibus_ready   (o_ibus_ready),
		.i_dbus_request (i_dbus_request),
		.i_dbus_rw      (i_dbus_rw),
		.i_dbus_address (i_dbus_address),
		.i_dbus_wdata   (i_dbus_wdata),
		.o_dbus_rdata   (o_dbus_rdata),
		.o_dbus_ready   (o_dbus_ready),
		.i_dma_request  (i_dma_request),
		.i_dma_rw       (i_dma_rw),
		.i_dma_address  (i_dma_address),
		.i_dma_wdata    (i_dma_wdata),
		.o_dma_rdata    (o_dma_rdata),
		.o_dma_ready    (o_dma_ready),
		.bus            (sys_bus.master)
	);

	main_bus_decode decode (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.sys     (sys_bus.slave),
		.ram     (ram_bus.master),
		.near    (near_bus.master)
	);

	block_ram ram (
		.i_clock (i_clock),
		.bus     (ram_bus.slave)
	);

	// Peripheral island
	peripheral_bridge bridge (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.near    (near_bus.slave),
		.timer   (timer_bus.master),
		.o_ledr  (o_ledr)
	);

	system_timer timer (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.bus     (timer_bus.slave),
		.o_irq   (o_timer_irq)
	);

endmodule

`default_nettype wire

// File: logic/system_timer.sv
`default_nettype none
`timescale 1ns/1ns

module system_timer (
	input  wire      i_clock,
	input  wire      i_rst,
	soc_bus_if.slave bus,
	output logic     o_irq
);
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;

	data_t count;
	data_t compare;
	logic enable;
	logic irq_pending;
	data_t rdata_q;
	logic ready_q;
	timer_reg_t reg_sel;
	logic access;
	logic wr_control;

	assign reg_sel    = bus.address[TIMER_REG_LSB +: TIMER_REG_W];
	assign access     = bus.request && !ready_q;
	assign wr_control = access && bus.rw && (reg_sel == TIMER_REG_CONTROL);

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			count       <= '0;
			compare     <= '0;
			enable      <= 1'b0;
			irq_pending <= 1'b0;
			ready_q     <= 1'b0;
		end else begin
			count   <= count + 1'b1;
			ready_q <= access;

			if (access && bus.rw && (reg_sel == TIMER_REG_COMPARE))
				compare <= bus.wdata;
			if (wr_control)
				enable <= bus.wdata[0];

			// Clear wins over a new match in the same cycle
			if (wr_control && bus.wdata[1])
				irq_pending <= 1'b0;
			else if (enable && (count >= compare))
				irq_pending <= 1'b1;
		end
	end

	// Register read-back
	always_ff @(posedge i_clock) begin
		if (access) begin
			case (reg_sel)
				TIMER_REG_COUNT:   rdata_q <= count;
				TIMER_REG_COMPARE: rdata_q <= compare;
				TIMER_REG_CONTROL: rdata_q <= {{(DATA_W-2){1'b0}}, irq_pending, enable};
				default:           rdata_q <= '0;
			endcase
		end
	end

	assign bus.rdata = rdata_q;
	assign bus.ready = ready_q;
	assign o_irq     = irq_pending;

	// No interrupt can appear out of a disabled, idle timer
	a_irq_cause: assert property (@(posedge i_clock) disable iff (i_rst)
		!enable && !irq_pending |=> !o_irq);

endmodule

`default_nettype wire

// File: logic/peripheral_bridge.sv
`default_nettype none
`timescale 1ns/1ns

module peripheral_bridge (
	input  wire                                 i_clock,
	input  wire                                 i_rst,
	soc_bus_if.slave                            near,
	soc_bus_if.master                           timer,
	output logic [soc_periph_pkg::LED_W-1:0]    o_ledr
);
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;

	logic busy;
	logic far_req;
	logic far_rw;
	addr_t far_addr;
	data_t far_wdata;
	logic near_ready_q;
	data_t near_rdata_q;

	periph_sel_t far_dev;
	logic led_sel;
	logic timer_sel;
	logic far_ready;
	data_t far_rdata;
	logic local_ready;
	logic [LED_W-1:0] ledr_q;

	// ========================================================================
	// Near side, one transaction at a time
	// ========================================================================
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			busy         <= 1'b0;
			far_req      <= 1'b0;
			near_ready_q <= 1'b0;
		end else begin
			near_ready_q <= 1'b0;
			if (!busy) begin
				if (near.request) begin
					busy    <= 1'b1;
					far_req <= 1'b1;
				end
			end else if (far_req) begin
				if (far_ready) begin
					far_req      <= 1'b0;
					near_ready_q <= 1'b1;
				end
			end else if (near_ready_q) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (!busy) begin
			far_rw    <= near.rw;
			far_addr  <= near.address;
			far_wdata <= near.wdata;
		end
		if (far_req && far_ready)
			near_rdata_q <= far_rdata;
	end

	assign near.rdata = near_rdata_q;
	assign near.ready = near_ready_q;

	// ========================================================================
	// Far bus
	// ========================================================================
	assign far_dev   = far_addr[PERIPH_SEL_MSB:PERIPH_SEL_LSB];
	assign led_sel   = (far_dev == PERIPH_LED);
	assign timer_sel = (far_dev == PERIPH_TIMER);

	assign timer.request = far_req && timer_sel;
	assign timer.rw      = far_rw;
	assign timer.address = far_addr;
	assign timer.wdata   = far_wdata;

	// LED register and unmapped devices answer here, reads give zero
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			local_ready <= 1'b0;
			ledr_q      <= '0;
		end else begin
			local_ready <= far_req && !timer_sel && !local_ready;
			if (far_req && led_sel && far_rw && !local_ready)
				ledr_q <= far_wdata[LED_W-1:0];
		end
	end

	assign far_ready = timer_sel ? timer.ready : local_ready;
	assign far_rdata = timer_sel ? timer.rdata : '0;

	assign o_ledr = ledr_q;

	a_far_hold: assert property (@(posedge i_clock) disable iff (i_rst)
		far_req && !far_ready |=> far_req);

endmodule

`default_nettype wire

// File: logic/block_ram.sv
`default_nettype none
`timescale 1ns/1ns

module block_ram (
	input  wire      i_clock,
	soc_bus_if.slave bus
);
	import soc_bus_pkg::*;

	data_t mem [RAM_WORDS];
	data_t rdata_q;
	logic ready_q;
	logic [RAM_IDX_W-1:0] index;
	logic access;

	// Byte address to word index
	assign index = bus.address[RAM_ADDR_LSH +: RAM_IDX_W];

	// The request is still high while ready shows, so skip that cycle
	assign access = bus.request && !ready_q;

	always_ff @(posedge i_clock) begin
		if (access && bus.rw)
			mem[index] <= bus.wdata;
		if (access)
			rdata_q <= mem[index];
	end

	always_ff @(posedge i_clock) begin
		ready_q <= access;
	end

	assign bus.rdata = rdata_q;
	assign bus.ready = ready_q;

endmodule

`default_nettype wire

// File: logic/main_bus_decode.sv
`default_nettype none
`timescale 1ns/1ns

module main_bus_decode (
	input  wire       i_clock,
	input  wire       i_rst,
	soc_bus_if.slave  sys,
	soc_bus_if.master ram,
	soc_bus_if.master near
);
	import soc_bus_pkg::*;

	region_t region;
	logic ram_sel;
	logic bridge_sel;
	addr_t local_address;
	logic unmapped_ready;

	assign region     = sys.address[REGION_MSB:REGION_LSB];
	assign ram_sel    = (region == REGION_RAM);
	assign bridge_sel = (region == REGION_BRIDGE);

	// Slaves see the address with the region nibble cleared
	assign local_address = {{(REGION_MSB-REGION_LSB+1){1'b0}}, sys.address[REGION_LSB-1:0]};

	assign ram.request = sys.request && ram_sel;
	assign ram.rw      = sys.rw;
	assign ram.address = local_address;
	assign ram.wdata   = sys.wdata;

	assign near.request = sys.request && bridge_sel;
	assign near.rw      = sys.rw;
	assign near.address = local_address;
	assign near.wdata   = sys.wdata;

	// Unmapped region answers with zero after one cycle
	always_ff @(posedge i_clock) begin
		if (i_rst)
			unmapped_ready <= 1'b0;
		else
			unmapped_ready <= sys.request && !ram_sel && !bridge_sel && !unmapped_ready;
	end

	assign sys.rdata =
		ram_sel    ? ram.rdata  :
		bridge_sel ? near.rdata :
		'0;

	assign sys.ready =
		ram_sel    ? ram.ready  :
		bridge_sel ? near.ready :
		unmapped_ready;

endmodule

`default_nettype wire

// File: logic/bus_arbiter.sv
`default_nettype none
`timescale 1ns/1ns

module bus_arbiter (
	input  wire                 i_clock,
	input  wire                 i_rst,

	// Instruction fetch
	input  wire                 i_ibus_request,
	input  wire soc_bus_pkg::addr_t i_ibus_address,
	output soc_bus_pkg::data_t  o_ibus_rdata,
	output logic                o_ibus_ready,

	// Data
	input  wire                 i_dbus_request,
	input  wire                 i_dbus_rw,
	input  wire soc_bus_pkg::addr_t i_dbus_address,
	input  wire soc_bus_pkg::data_t i_dbus_wdata,
	output soc_bus_pkg::data_t  o_dbus_rdata,
	output logic                o_dbus_ready,

	// DMA
	input  wire                 i_dma_request,
	input  wire                 i_dma_rw,
	input  wire soc_bus_pkg::addr_t i_dma_address,
	input  wire soc_bus_pkg::data_t i_dma_wdata,
	output soc_bus_pkg::data_t  o_dma_rdata,
	output logic                o_dma_ready,

	soc_bus_if.master           bus
);
	import soc_bus_pkg::*;

	logic [NUM_PORTS-1:0] pending;
	port_idx_t pick;
	port_idx_t owner;
	logic busy;
	logic rw_q;
	addr_t address_q;
	data_t wdata_q;

	assign pending[PORT_IBUS] = i_ibus_request;
	assign pending[PORT_DBUS] = i_dbus_request;
	assign pending[PORT_DMA]  = i_dma_request;

	// Fixed priority, ibus first
	always_comb begin
		if (pending[PORT_IBUS])
			pick = PORT_IBUS;
		else if (pending[PORT_DBUS])
			pick = PORT_DBUS;
		else
			pick = PORT_DMA;
	end

	// Grant only between transactions; the cycle after ready is always idle
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			busy  <= 1'b0;
			owner <= PORT_IBUS;
		end else if (!busy) begin
			if (|pending) begin
				busy  <= 1'b1;
				owner <= pick;
			end
		end else if (bus.ready) begin
			busy <= 1'b0;
		end
	end

	// Capture the winner's transaction
	always_ff @(posedge i_clock) begin
		if (!busy) begin
			case (pick)
				PORT_IBUS: begin
					rw_q      <= 1'b0;
					address_q <= i_ibus_address;
					wdata_q   <= '0;
				end
				PORT_DBUS: begin
					rw_q      <= i_dbus_rw;
					address_q <= i_dbus_address;
					wdata_q   <= i_dbus_wdata;
				end
				default: begin
					rw_q      <= i_dma_rw;
					address_q <= i_dma_address;
					wdata_q   <= i_dma_wdata;
				end
			endcase
		end
	end

	assign bus.request = busy;
	assign bus.rw      = rw_q;
	assign bus.address = address_q;
	assign bus.wdata   = wdata_q;

	// Response goes back in the same cycle, ready only to the owner
	assign o_ibus_rdata = bus.rdata;
	assign o_dbus_rdata = bus.rdata;
	assign o_dma_rdata  = bus.rdata;

	assign o_ibus_ready = busy && bus.ready && (owner == PORT_IBUS);
	assign o_dbus_ready = busy && bus.ready && (owner == PORT_DBUS);
	assign o_dma_ready  = busy && bus.ready && (owner == PORT_DMA);

	a_bus_stable: assert property (@(posedge i_clock) disable iff (i_rst)
		bus.request && !bus.ready |=> bus.request && $stable(bus.address)
			&& $stable(bus.rw) && $stable(bus.wdata));

	// At most one port is answered, and only one that is still waiting
	a_ready_owner: assert property (@(posedge i_clock) disable iff (i_rst)
		$onehot0({o_dma_ready, o_dbus_ready, o_ibus_ready})
			&& (!o_ibus_ready || i_ibus_request)
			&& (!o_dbus_ready || i_dbus_request)
			&& (!o_dma_ready || i_dma_request));

endmodule

`default_nettype wire

// File: logic/soc_bus_if.sv
`default_nettype none
`timescale 1ns/1ns

interface soc_bus_if;
	import soc_bus_pkg::*;

	// Master side
	logic  request;
	logic  rw;
	addr_t address;
	data_t wdata;

	// Slave side, ready is a single-cycle pulse
	data_t rdata;
	logic  ready;

	modport master (
		output request, rw, address, wdata,
		input  rdata, ready
	);

	modport slave (
		input  request, rw, address, wdata,
		output rdata, ready
	);

endinterface

`default_nettype wire

// File: logic/soc_periph_pkg.sv
`default_nettype none

package soc_periph_pkg;

	// Far-bus device select field
	localparam int PERIPH_SEL_MSB = 27;
	localparam int PERIPH_SEL_LSB = 24;

	typedef logic [PERIPH_SEL_MSB-PERIPH_SEL_LSB:0] periph_sel_t;

	localparam periph_sel_t PERIPH_LED   = 4'h0;
	localparam periph_sel_t PERIPH_TIMER = 4'h5;

	// Red LEDs on the board
	localparam int LED_W = 10;

	// Timer register offsets, word addressed from bit 2
	localparam int TIMER_REG_LSB = 2;
	localparam int TIMER_REG_W   = 2;

	typedef logic [TIMER_REG_W-1:0] timer_reg_t;

	localparam timer_reg_t TIMER_REG_COUNT   = 2'd0;
	localparam timer_reg_t TIMER_REG_COMPARE = 2'd1;
	// bit 0 enable, bit 1 pending (write one to clear)
	localparam timer_reg_t TIMER_REG_CONTROL = 2'd2;

endpackage

`default_nettype wire

// File: logic/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

	// ========================================================================
	// System bus widths
	// ========================================================================
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// ========================================================================
	// Address map, region in the top nibble
	// ========================================================================
	localparam int REGION_MSB = 31;
	localparam int REGION_LSB = 28;

	typedef logic [REGION_MSB-REGION_LSB:0] region_t;

	localparam region_t REGION_RAM    = 4'h1;
	localparam region_t REGION_BRIDGE = 4'h5;

	// On-chip RAM, 512 words of 32 bits
	localparam int RAM_WORDS    = 512;
	localparam int RAM_ADDR_LSH = 2;
	localparam int RAM_IDX_W    = $clog2(RAM_WORDS);

	// Arbiter ports, lowest index wins
	localparam int NUM_PORTS = 3;

	typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

	localparam port_idx_t PORT_IBUS = 0;
	localparam port_idx_t PORT_DBUS = 1;
	localparam port_idx_t PORT_DMA  = 2;

endpackage

`default_nettype wire
